// File: vlog.f
exe_pkg.sv
exe_result_if.sv
operand_forward.sv
int_alu.sv
branch_resolve.sv
mul_pipe.sv
exe_stage.sv
tb_exe_stage.sv

// File: Bender.yml
package:
  name: exe_stage

sources:
  - exe_pkg.sv
  - exe_result_if.sv
  - operand_forward.sv
  - int_alu.sv
  - branch_resolve.sv
  - mul_pipe.sv
  - exe_stage.sv
  - target: simulation
    files:
      - tb_exe_stage.sv

// File: tb_exe_stage.sv
`timescale 1ns/10ps

module tb_exe_stage import exe_pkg::*; ();

    logic      clk, rst, flush_ext;
    logic      eu0_en, eu0_use_imm, eu1_en, eu1_use_imm;
    kind_t     eu0_kind;
    func_t     eu0_func, eu1_func;
    reg_addr_t eu0_rd, eu0_rj, eu0_rk, eu1_rd, eu1_rj, eu1_rk;
    word_t     eu0_imm, eu0_pc, eu0_pc_next, data00, data01;
    word_t     eu1_imm, eu1_pc, data10, data11;
    logic      en_out0, en_out1, branch_valid, branch_taken, flush;
    reg_addr_t addr_out0, addr_out1;
    word_t     data_out0, pc_out0, data_out1, pc_out1, branch_pc, correct_pc;

    // next bundle as filled by the tests
    logic      n_en[2], n_use[2];
    kind_t     n_kind;
    func_t     n_func[2];
    reg_addr_t n_rd[2], n_rj[2], n_rk[2];
    word_t     n_imm[2];
    word_t     n_pcn;
    word_t     pc_ctr;
    logic      doom_all, ext_pulse, flush_pending;

    // reference model state
    word_t     ref_rf[NUM_REGS];
    word_t     com_rf[NUM_REGS];
    logic      wq_en[3][2];
    reg_addr_t wq_rd[3][2];
    word_t     wq_d[3][2];

    // expected outputs are p at issue and e delayed to the sampling edge
    logic      p_en[2], e_en[2][2];
    reg_addr_t p_rd[2], e_rd[2][2];
    word_t     p_d[2], e_d[2][2], p_pc[2], e_pc[2][2];
    logic      p_bv, p_bt, p_fl, b_bv, b_bt, b_fl;
    word_t     p_bpc, p_cpc, b_bpc, b_cpc;

    int errors, tests, failed_tests, err_mark;

    exe_stage UUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #2000000;
        $display("simulation did not finish in time");
        $display("tests failed");
        $finish;
    end

    always @(posedge clk) begin
        for (int l = 0; l < 2; l++) begin
            e_en[0][l] <= p_en[l];
            e_rd[0][l] <= p_rd[l];
            e_d[0][l]  <= p_d[l];
            e_pc[0][l] <= p_pc[l];
            e_en[1][l] <= e_en[0][l];
            e_rd[1][l] <= e_rd[0][l];
            e_d[1][l]  <= e_d[0][l];
            e_pc[1][l] <= e_pc[0][l];
        end
        b_bv  <= p_bv;
        b_bt  <= p_bt;
        b_fl  <= p_fl;
        b_bpc <= p_bpc;
        b_cpc <= p_cpc;
    end

    task automatic mismatch(input string name, input word_t got, input word_t exp);
        errors++;
        $display("ERROR %s got %h expected %h", name, got, exp);
    endtask

    a_en0: assert property (@(posedge clk) disable iff (rst) en_out0 == e_en[1][0])
        else mismatch("en_out0", $sampled(en_out0), $sampled(e_en[1][0]));
    a_rd0: assert property (@(posedge clk) disable iff (rst)
        e_en[1][0] |-> addr_out0 == e_rd[1][0])
        else mismatch("addr_out0", $sampled(addr_out0), $sampled(e_rd[1][0]));
    a_d0: assert property (@(posedge clk) disable iff (rst)
        e_en[1][0] |-> data_out0 == e_d[1][0])
        else mismatch("data_out0", $sampled(data_out0), $sampled(e_d[1][0]));
    a_pc0: assert property (@(posedge clk) disable iff (rst)
        e_en[1][0] |-> pc_out0 == e_pc[1][0])
        else mismatch("pc_out0", $sampled(pc_out0), $sampled(e_pc[1][0]));
    a_en1: assert property (@(posedge clk) disable iff (rst) en_out1 == e_en[1][1])
        else mismatch("en_out1", $sampled(en_out1), $sampled(e_en[1][1]));
    a_rd1: assert property (@(posedge clk) disable iff (rst)
        e_en[1][1] |-> addr_out1 == e_rd[1][1])
        else mismatch("addr_out1", $sampled(addr_out1), $sampled(e_rd[1][1]));
    a_d1: assert property (@(posedge clk) disable iff (rst)
        e_en[1][1] |-> data_out1 == e_d[1][1])
        else mismatch("data_out1", $sampled(data_out1), $sampled(e_d[1][1]));
    a_pc1: assert property (@(posedge clk) disable iff (rst)
        e_en[1][1] |-> pc_out1 == e_pc[1][1])
        else mismatch("pc_out1", $sampled(pc_out1), $sampled(e_pc[1][1]));
    a_bv: assert property (@(posedge clk) disable iff (rst) branch_valid == b_bv)
        else mismatch("branch_valid", $sampled(branch_valid), $sampled(b_bv));
    a_fl: assert property (@(posedge clk) disable iff (rst) flush == b_fl)
        else mismatch("flush", $sampled(flush), $sampled(b_fl));
    a_bt: assert property (@(posedge clk) disable iff (rst) b_bv |-> branch_taken == b_bt)
        else mismatch("branch_taken", $sampled(branch_taken), $sampled(b_bt));
    a_bpc: assert property (@(posedge clk) disable iff (rst) b_bv |-> branch_pc == b_bpc)
        else mismatch("branch_pc", $sampled(branch_pc), $sampled(b_bpc));
    a_cpc: assert property (@(posedge clk) disable iff (rst) b_bv |-> correct_pc == b_cpc)
        else mismatch("correct_pc", $sampled(correct_pc), $sampled(b_cpc));

    function automatic word_t alu_ref(input func_t op, input word_t a, input word_t b);
        case (op)
            4'd0:    return a + b;
            4'd1:    return a - b;
            4'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4'd3:    return (a < b) ? 32'd1 : 32'd0;
            4'd4:    return a & b;
            4'd5:    return a | b;
            4'd6:    return a ^ b;
            4'd7:    return ~(a | b);
            4'd8:    return a << b[4:0];
            4'd9:    return a >> b[4:0];
            4'd10:   return $unsigned($signed(a) >>> b[4:0]);
            4'd11:   return b;
            default: return '0;
        endcase
    endfunction

    function automatic word_t mul_ref(input func_t op, input word_t a, input word_t b);
        logic [63:0] p;
        if (op[1:0] == MUL_HIU) begin
            p = {32'b0, a} * {32'b0, b};
        end else begin
            p = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        end
        return (op[1:0] == MUL_LO) ? p[31:0] : p[63:32];
    endfunction

    function automatic logic br_cond(input func_t op, input word_t a, input word_t b);
        case (op)
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return $signed(a) < $signed(b);
            BR_BGE:  return $signed(a) >= $signed(b);
            BR_BLTU: return a < b;
            BR_BGEU: return a >= b;
            default: return 1'b1;
        endcase
    endfunction

    function automatic word_t br_dest(input func_t op, input word_t pc, input word_t a,
                                      input word_t imm);
        return (op == BR_JIRL) ? a + imm : pc + imm;
    endfunction

    function automatic word_t rd_ref(input reg_addr_t r);
        return (r == '0) ? '0 : ref_rf[r];
    endfunction

    function automatic logic busy();
        logic b;
        b = p_en[0] || p_en[1] || p_bv;
        for (int s = 0; s < 3; s++) begin
            b = b || wq_en[s][0] || wq_en[s][1];
        end
        return b || e_en[0][0] || e_en[0][1] || e_en[1][0] || e_en[1][1] || b_bv;
    endfunction

    // retire, run the model and drive the bundle at one clock edge
    task automatic issue_cycle();
        word_t a[2], b[2], r[2], dest;
        logic  w[2], kill[2], br, mis, tk;
        @(posedge clk);
        for (int l = 0; l < 2; l++) begin
            if (wq_en[2][l] && wq_rd[2][l] != '0) com_rf[wq_rd[2][l]] = wq_d[2][l];
        end
        for (int s = 2; s > 0; s--) begin
            for (int l = 0; l < 2; l++) begin
                wq_en[s][l] = wq_en[s-1][l];
                wq_rd[s][l] = wq_rd[s-1][l];
                wq_d[s][l]  = wq_d[s-1][l];
            end
        end
        kill[0] = flush_pending || doom_all;
        kill[1] = kill[0];
        flush_pending = 1'b0;
        for (int l = 0; l < 2; l++) begin
            a[l] = rd_ref(n_rj[l]);
            b[l] = rd_ref(n_rk[l]);
        end
        br   = n_en[0] && (n_kind == KIND_BR) && !kill[0];
        tk   = br_cond(n_func[0], a[0], b[0]);
        dest = br_dest(n_func[0], pc_ctr, a[0], n_imm[0]);
        mis  = br && ((tk ? dest : pc_ctr + 4) != n_pcn);
        case (n_kind)
            KIND_MUL: begin
                r[0] = mul_ref(n_func[0], a[0], b[0]);
                w[0] = 1'b1;
            end
            KIND_BR: begin
                r[0] = pc_ctr + 4;
                w[0] = (n_func[0] == BR_BL) || (n_func[0] == BR_JIRL);
            end
            default: begin
                r[0] = alu_ref(n_func[0], a[0], n_use[0] ? n_imm[0] : b[0]);
                w[0] = 1'b1;
            end
        endcase
        if (mis) begin
            kill[1] = 1'b1;
            flush_pending = 1'b1;
        end
        r[1] = alu_ref(n_func[1], a[1], n_use[1] ? n_imm[1] : b[1]);
        w[1] = 1'b1;
        for (int l = 0; l < 2; l++) begin
            w[l] = w[l] && n_en[l] && !kill[l];
            if (w[l] && n_rd[l] != '0) ref_rf[n_rd[l]] = r[l];
            wq_en[0][l] = w[l];
            wq_rd[0][l] = n_rd[l];
            wq_d[0][l]  = r[l];
            p_en[l] <= w[l];
            p_rd[l] <= n_rd[l];
            p_d[l]  <= r[l];
            p_pc[l] <= pc_ctr + 4 * l;
        end
        p_bv  <= br;
        p_bt  <= br && tk;
        p_fl  <= mis;
        p_bpc <= pc_ctr;
        p_cpc <= tk ? dest : pc_ctr + 4;
        eu0_en <= n_en[0];
        eu0_kind <= n_kind;
        eu0_func <= n_func[0];
        eu0_rd <= n_rd[0];
        eu0_rj <= n_rj[0];
        eu0_rk <= n_rk[0];
        eu0_imm <= n_imm[0];
        eu0_use_imm <= n_use[0];
        eu0_pc <= pc_ctr;
        eu0_pc_next <= n_pcn;
        data00 <= com_rf[n_rj[0]];
        data01 <= com_rf[n_rk[0]];
        eu1_en <= n_en[1];
        eu1_func <= n_func[1];
        eu1_rd <= n_rd[1];
        eu1_rj <= n_rj[1];
        eu1_rk <= n_rk[1];
        eu1_imm <= n_imm[1];
        eu1_use_imm <= n_use[1];
        eu1_pc <= pc_ctr + 4;
        data10 <= com_rf[n_rj[1]];
        data11 <= com_rf[n_rk[1]];
        flush_ext <= ext_pulse;
        pc_ctr = pc_ctr + 8;
    endtask

    task automatic clear_bundle();
        n_en[0] = 1'b0;
        n_en[1] = 1'b0;
        n_kind  = KIND_ALU;
    endtask

    task automatic set_op(input int l, input func_t f, input reg_addr_t rd,
                          input reg_addr_t rj, input reg_addr_t rk, input logic use_imm,
                          input word_t imm);
        n_en[l]   = 1'b1;
        n_func[l] = f;
        n_rd[l]   = rd;
        n_rj[l]   = rj;
        n_rk[l]   = rk;
        n_use[l]  = use_imm;
        n_imm[l]  = imm;
    endtask

    task automatic rand_alu(input int l, input int span);
        set_op(l, func_t'($urandom % 12), reg_addr_t'(1 + $urandom % span),
               reg_addr_t'($urandom % (span + 1)), reg_addr_t'($urandom % (span + 1)),
               logic'($urandom % 2), $urandom);
    endtask

    task automatic drain();
        int n;
        n = 0;
        clear_bundle();
        while (busy() && n < 8) begin
            issue_cycle();
            n++;
        end
        if (busy()) begin
            errors++;
            $display("pipeline did not drain within 8 cycles");
        end
        issue_cycle();
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: FAILED with %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        func_t br_ops[9];
        word_t good;
        void'($urandom(82636));
        br_ops = '{BR_JIRL, BR_B, BR_BL, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
        rst = 1'b1;
        flush_ext = 1'b0;
        eu0_en = 1'b0;
        eu0_kind = KIND_ALU;
        eu0_func = '0;
        eu0_rd = '0;
        eu0_rj = '0;
        eu0_rk = '0;
        eu0_imm = '0;
        eu0_use_imm = 1'b0;
        eu0_pc = '0;
        eu0_pc_next = '0;
        data00 = '0;
        data01 = '0;
        eu1_en = 1'b0;
        eu1_func = '0;
        eu1_rd = '0;
        eu1_rj = '0;
        eu1_rk = '0;
        eu1_imm = '0;
        eu1_use_imm = 1'b0;
        eu1_pc = '0;
        data10 = '0;
        data11 = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            ref_rf[i] = '0;
            com_rf[i] = '0;
        end
        for (int l = 0; l < 2; l++) begin
            p_en[l] = 1'b0;
            p_rd[l] = '0;
            p_d[l]  = '0;
            p_pc[l] = '0;
            for (int s = 0; s < 3; s++) wq_en[s][l] = 1'b0;
            for (int s = 0; s < 2; s++) e_en[s][l] = 1'b0;
        end
        p_bv  = 1'b0;
        p_bt  = 1'b0;
        p_fl  = 1'b0;
        p_bpc = '0;
        p_cpc = '0;
        b_bv  = 1'b0;
        b_fl  = 1'b0;
        doom_all = 1'b0;
        ext_pulse = 1'b0;
        flush_pending = 1'b0;
        pc_ctr = 32'h1c00_0000;
        n_pcn  = '0;
        errors = 0;
        tests = 0;
        failed_tests = 0;
        err_mark = 0;
        for (int l = 0; l < 2; l++) set_op(l, '0, '0, '0, '0, 1'b0, '0);
        clear_bundle();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        #1;
        a_reset: assert (!(en_out0 || en_out1 || branch_valid || flush)) else begin
            errors++;
            $display("an output was high right after reset");
        end
        end_test("reset");

        repeat (60) begin
            clear_bundle();
            if ($urandom % 4 != 0) rand_alu(0, 31);
            if ($urandom % 4 != 0) rand_alu(1, 31);
            issue_cycle();
        end
        drain();
        end_test("alu");

        // lane 1 and lane 0 write r7 together and lane 1 must win
        clear_bundle();
        set_op(0, func_t'(ALU_LUI), 5'd7, 5'd0, 5'd0, 1'b1, 32'h1111_0000);
        set_op(1, func_t'(ALU_LUI), 5'd7, 5'd0, 5'd0, 1'b1, 32'h2222_0000);
        issue_cycle();
        clear_bundle();
        set_op(0, func_t'(ALU_ADD), 5'd8, 5'd7, 5'd0, 1'b1, 32'd1);
        issue_cycle();
        clear_bundle();
        set_op(1, func_t'(ALU_OR), 5'd9, 5'd7, 5'd8, 1'b0, '0);
        issue_cycle();
        clear_bundle();
        set_op(0, func_t'(ALU_ADD), 5'd0, 5'd7, 5'd7, 1'b0, '0);
        issue_cycle();
        clear_bundle();
        set_op(0, func_t'(ALU_ADD), 5'd10, 5'd0, 5'd7, 1'b0, '0);
        set_op(1, func_t'(ALU_SUB), 5'd11, 5'd0, 5'd0, 1'b1, 32'd5);
        issue_cycle();
        repeat (40) begin
            clear_bundle();
            if ($urandom % 5 != 0) rand_alu(0, 3);
            if ($urandom % 5 != 0) rand_alu(1, 3);
            issue_cycle();
        end
        drain();
        end_test("forwarding");

        repeat (30) begin
            clear_bundle();
            set_op(0, func_t'(ALU_LUI), 5'd10, 5'd0, 5'd0, 1'b1, $urandom);
            set_op(1, func_t'(ALU_LUI), 5'd11, 5'd0, 5'd0, 1'b1, $urandom);
            issue_cycle();
            clear_bundle();
            n_kind = KIND_MUL;
            set_op(0, func_t'($urandom % 3), reg_addr_t'(12 + $urandom % 8), 5'd10, 5'd11,
                   1'b0, '0);
            issue_cycle();
            // the product is not forwarded from the mid level
            clear_bundle();
            issue_cycle();
        end
        drain();
        end_test("multiply");

        foreach (br_ops[i]) begin
            for (int wrong = 0; wrong < 2; wrong++) begin
                clear_bundle();
                set_op(0, func_t'(ALU_LUI), 5'd12, 5'd0, 5'd0, 1'b1, $urandom % 4);
                set_op(1, func_t'(ALU_LUI), 5'd13, 5'd0, 5'd0, 1'b1, $urandom % 4 - 2);
                issue_cycle();
                clear_bundle();
                n_kind = KIND_BR;
                set_op(0, br_ops[i], 5'd1, 5'd12, 5'd13, 1'b0, ($urandom % 256) * 4);
                rand_alu(1, 31);
                good = br_cond(br_ops[i], rd_ref(5'd12), rd_ref(5'd13))
                     ? br_dest(br_ops[i], pc_ctr, rd_ref(5'd12), n_imm[0]) : pc_ctr + 4;
                n_pcn = (wrong != 0) ? good + 8 : good;
                issue_cycle();
                clear_bundle();
                rand_alu(0, 31);
                rand_alu(1, 31);
                issue_cycle();
                drain();
            end
        end
        end_test("branch");

        repeat (3) begin
            clear_bundle();
            rand_alu(0, 31);
            rand_alu(1, 31);
            issue_cycle();
        end
        doom_all = 1'b1;
        clear_bundle();
        n_kind = KIND_MUL;
        set_op(0, func_t'(MUL_LO), 5'd20, 5'd3, 5'd4, 1'b0, '0);
        rand_alu(1, 31);
        issue_cycle();
        // a multiply taken in the flush_ext cycle must die inside the multiplier
        clear_bundle();
        n_kind = KIND_MUL;
        set_op(0, func_t'(MUL_HI), 5'd21, 5'd5, 5'd6, 1'b0, '0);
        rand_alu(1, 31);
        ext_pulse = 1'b1;
        issue_cycle();
        doom_all = 1'b0;
        ext_pulse = 1'b0;
        drain();
        end_test("external flush");

        $display("tests run %0d, tests failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: exe_stage.sv
`timescale 1ns/10ps

module exe_stage import exe_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      flush_ext,
    // lane 0
    input  logic      eu0_en,
    input  kind_t     eu0_kind,
    input  func_t     eu0_func,
    input  reg_addr_t eu0_rd,
    input  reg_addr_t eu0_rj,
    input  reg_addr_t eu0_rk,
    input  word_t     eu0_imm,
    input  logic      eu0_use_imm,
    input  word_t     eu0_pc,
    input  word_t     eu0_pc_next,
    input  word_t     data00,
    input  word_t     data01,
    // lane 1, alu only
    input  logic      eu1_en,
    input  func_t     eu1_func,
    input  reg_addr_t eu1_rd,
    input  reg_addr_t eu1_rj,
    input  reg_addr_t eu1_rk,
    input  word_t     eu1_imm,
    input  logic      eu1_use_imm,
    input  word_t     eu1_pc,
    input  word_t     data10,
    input  word_t     data11,
    // writeback
    output logic      en_out0,
    output reg_addr_t addr_out0,
    output word_t     data_out0,
    output word_t     pc_out0,
    output logic      en_out1,
    output reg_addr_t addr_out1,
    output word_t     data_out1,
    output word_t     pc_out1,
    // branch feedback
    output logic      branch_valid,
    output logic      branch_taken,
    output word_t     branch_pc,
    output logic      flush,
    output word_t     correct_pc
);

    exe_result_if mid0 ();
    exe_result_if mid1 ();
    exe_result_if out0 ();
    exe_result_if out1 ();

    word_t     eu0_sr0, eu0_sr1, eu1_sr0, eu1_sr1;
    word_t     alu0_b, alu1_b;
    word_t     alu0_result, alu1_result;
    logic      issue0, issue1;
    logic      alu0_en, mul_en, br_en;
    logic      br_taken, br_link_en, br_mispredict;
    word_t     br_target, br_link_data;
    logic      mul_res_en;
    reg_addr_t mul_res_rd;
    word_t     mul_result;

    // nothing is taken in the flush cycle; lane 1 dies with a mispredicted partner
    assign issue0  = eu0_en && !flush;
    assign issue1  = eu1_en && !flush && !br_mispredict;
    assign alu0_en = issue0 && (eu0_kind == KIND_ALU);
    assign mul_en  = issue0 && (eu0_kind == KIND_MUL);
    assign br_en   = issue0 && (eu0_kind == KIND_BR);

    assign alu0_b = eu0_use_imm ? eu0_imm : eu0_sr1;
    assign alu1_b = eu1_use_imm ? eu1_imm : eu1_sr1;

    operand_forward u_forward (
        .eu0_rj  (eu0_rj),
        .eu0_rk  (eu0_rk),
        .eu1_rj  (eu1_rj),
        .eu1_rk  (eu1_rk),
        .data00  (data00),
        .data01  (data01),
        .data10  (data10),
        .data11  (data11),
        .mid0    (mid0),
        .mid1    (mid1),
        .out0    (out0),
        .out1    (out1),
        .eu0_sr0 (eu0_sr0),
        .eu0_sr1 (eu0_sr1),
        .eu1_sr0 (eu1_sr0),
        .eu1_sr1 (eu1_sr1)
    );

    int_alu u_alu0 (
        .op     (alu_op_t'(eu0_func)),
        .a      (eu0_sr0),
        .b      (alu0_b),
        .result (alu0_result)
    );

    int_alu u_alu1 (
        .op     (alu_op_t'(eu1_func)),
        .a      (eu1_sr0),
        .b      (alu1_b),
        .result (alu1_result)
    );

    branch_resolve u_branch (
        .en         (br_en),
        .op         (br_op_t'(eu0_func)),
        .pc         (eu0_pc),
        .pc_next    (eu0_pc_next),
        .sr0        (eu0_sr0),
        .sr1        (eu0_sr1),
        .imm        (eu0_imm),
        .taken      (br_taken),
        .target     (br_target),
        .link_en    (br_link_en),
        .link_data  (br_link_data),
        .mispredict (br_mispredict)
    );

    mul_pipe u_mul (
        .clk    (clk),
        .rst    (rst),
        .kill   (flush_ext),
        .en     (mul_en),
        .op     (mul_op_t'(eu0_func[1:0])),
        .rd     (eu0_rd),
        .a      (eu0_sr0),
        .b      (eu0_sr1),
        .res_en (mul_res_en),
        .res_rd (mul_res_rd),
        .result (mul_result)
    );

    // mid level
    always_ff @(posedge clk) begin
        if (rst || flush_ext) begin
            mid0.en      <= 1'b0;
            mid1.en      <= 1'b0;
            branch_valid <= 1'b0;
            branch_taken <= 1'b0;
            flush        <= 1'b0;
        end else begin
            // a multiply has no result here
            mid0.en      <= alu0_en || br_link_en;
            mid1.en      <= issue1;
            branch_valid <= br_en;
            branch_taken <= br_taken;
            flush        <= br_mispredict;
        end
    end

    always_ff @(posedge clk) begin
        mid0.rd    <= eu0_rd;
        mid0.data  <= (eu0_kind == KIND_BR) ? br_link_data : alu0_result;
        mid0.pc    <= eu0_pc;
        mid1.rd    <= eu1_rd;
        mid1.data  <= alu1_result;
        mid1.pc    <= eu1_pc;
        correct_pc <= br_taken ? br_target : br_link_data;
    end

    // out level, the multiplier joins lane 0 here
    always_ff @(posedge clk) begin
        if (rst || flush_ext) begin
            out0.en <= 1'b0;
            out1.en <= 1'b0;
        end else begin
            out0.en <= mid0.en || mul_res_en;
            out1.en <= mid1.en;
        end
    end

    always_ff @(posedge clk) begin
        out0.rd   <= mul_res_en ? mul_res_rd : mid0.rd;
        out0.data <= mul_res_en ? mul_result : mid0.data;
        out0.pc   <= mid0.pc;
        out1.rd   <= mid1.rd;
        out1.data <= mid1.data;
        out1.pc   <= mid1.pc;
    end

    assign branch_pc = mid0.pc;

    assign en_out0   = out0.en;
    assign addr_out0 = out0.rd;
    assign data_out0 = out0.data;
    assign pc_out0   = out0.pc;
    assign en_out1   = out1.en;
    assign addr_out1 = out1.rd;
    assign data_out1 = out1.data;
    assign pc_out1   = out1.pc;

endmodule

// File: mul_pipe.sv
`timescale 1ns/10ps

module mul_pipe import exe_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      kill,
    input  logic      en,
    input  mul_op_t   op,
    input  reg_addr_t rd,
    input  word_t     a,
    input  word_t     b,
    output logic      res_en,
    output reg_addr_t res_rd,
    output word_t     result
);

    logic [HALF_W-1:0]   a_lo, a_hi, b_lo, b_hi;
    logic                is_signed;
    word_t               adj;
    logic                valid_q;
    mul_op_t             op_q;
    reg_addr_t           rd_q;
    word_t               pp_ll, pp_lh, pp_hl, pp_hh, adj_q;
    logic [2*WORD_W-1:0] sum;

    assign {a_hi, a_lo} = a;
    assign {b_hi, b_lo} = b;

    // signed high word = unsigned high word minus the cross terms of the sign bits
    assign is_signed = (op != MUL_HIU);
    assign adj = ((is_signed && a[WORD_W-1]) ? b : '0) + ((is_signed && b[WORD_W-1]) ? a : '0);

    always_ff @(posedge clk) begin
        if (rst || kill) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= en;
        end
    end

    always_ff @(posedge clk) begin
        op_q  <= op;
        rd_q  <= rd;
        pp_ll <= a_lo * b_lo;
        pp_lh <= a_lo * b_hi;
        pp_hl <= a_hi * b_lo;
        pp_hh <= a_hi * b_hi;
        adj_q <= adj;
    end

    // second level
    assign sum = {pp_hh, pp_ll}
               + {{HALF_W{1'b0}}, pp_lh, {HALF_W{1'b0}}}
               + {{HALF_W{1'b0}}, pp_hl, {HALF_W{1'b0}}};

    always_comb begin
        case (op_q)
            MUL_LO: begin
                result = sum[WORD_W-1:0];
            end
            MUL_HI, MUL_HIU: begin
                result = sum[2*WORD_W-1:WORD_W] - adj_q;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign res_en = valid_q;
    assign res_rd = rd_q;

endmodule

// File: branch_resolve.sv
`timescale 1ns/10ps

module branch_resolve import exe_pkg::*; (
    input  logic   en,
    input  br_op_t op,
    input  word_t  pc,
    input  word_t  pc_next,
    input  word_t  sr0,
    input  word_t  sr1,
    input  word_t  imm,
    output logic   taken,
    output word_t  target,
    output logic   link_en,
    output word_t  link_data,
    output logic   mispredict
);

    logic  cond;
    word_t actual_next;

    always_comb begin
        case (op)
            BR_JIRL, BR_B, BR_BL: begin
                cond = 1'b1;
            end
            BR_BEQ: begin
                cond = (sr0 == sr1);
            end
            BR_BNE: begin
                cond = (sr0 != sr1);
            end
            BR_BLT: begin
                cond = ($signed(sr0) < $signed(sr1));
            end
            BR_BGE: begin
                cond = ($signed(sr0) >= $signed(sr1));
            end
            BR_BLTU: begin
                cond = (sr0 < sr1);
            end
            BR_BGEU: begin
                cond = (sr0 >= sr1);
            end
            default: begin
                cond = 1'b0;
            end
        endcase
    end

    // jirl is register relative, the rest pc relative
    assign target    = (op == BR_JIRL) ? (sr0 + imm) : (pc + imm);
    assign link_data = pc + word_t'(LINK_OFFSET);

    assign actual_next = cond ? target : link_data;

    assign taken      = en && cond;
    assign link_en    = en && ((op == BR_BL) || (op == BR_JIRL));
    assign mispredict = en && (actual_next != pc_next);

endmodule

// File: int_alu.sv
`timescale 1ns/10ps

module int_alu import exe_pkg::*; (
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result
);

    logic [SHAMT_W-1:0] shamt;

    assign shamt = b[SHAMT_W-1:0];

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_SLT: begin
                result = {{(WORD_W-1){1'b0}}, ($signed(a) < $signed(b))};
            end
            ALU_SLTU: begin
                result = {{(WORD_W-1){1'b0}}, (a < b)};
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_NOR: begin
                result = ~(a | b);
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            ALU_SRL: begin
                result = a >> shamt;
            end
            ALU_SRA: begin
                result = word_t'($signed(a) >>> shamt);
            end
            // immediate arrives already shifted into place
            ALU_LUI: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: operand_forward.sv
`timescale 1ns/10ps

module operand_forward import exe_pkg::*; (
    input  reg_addr_t         eu0_rj,
    input  reg_addr_t         eu0_rk,
    input  reg_addr_t         eu1_rj,
    input  reg_addr_t         eu1_rk,
    input  word_t             data00,
    input  word_t             data01,
    input  word_t             data10,
    input  word_t             data11,
    exe_result_if.sink        mid0,
    exe_result_if.sink        mid1,
    exe_result_if.sink        out0,
    exe_result_if.sink        out1,
    output word_t             eu0_sr0,
    output word_t             eu0_sr1,
    output word_t             eu1_sr0,
    output word_t             eu1_sr1
);

    // newest producer first; lane 1 is younger than lane 0 at the same level
    function automatic word_t pick(input reg_addr_t src, input word_t rf);
        if (src == '0) begin
            return '0;
        end
        if (mid1.en && (mid1.rd == src)) begin
            return mid1.data;
        end
        if (mid0.en && (mid0.rd == src)) begin
            return mid0.data;
        end
        if (out1.en && (out1.rd == src)) begin
            return out1.data;
        end
        if (out0.en && (out0.rd == src)) begin
            return out0.data;
        end
        return rf;
    endfunction

    assign eu0_sr0 = pick(eu0_rj, data00);
    assign eu0_sr1 = pick(eu0_rk, data01);
    assign eu1_sr0 = pick(eu1_rj, data10);
    assign eu1_sr1 = pick(eu1_rk, data11);

endmodule

// File: exe_result_if.sv
`timescale 1ns/10ps

// one lane's result at one pipeline level
interface exe_result_if import exe_pkg::*; ();

    logic      en;
    reg_addr_t rd;
    word_t     data;
    word_t     pc;

    modport src (
        output en,
        output rd,
        output data,
        output pc
    );

    modport sink (
        input en,
        input rd,
        input data,
        input pc
    );

endinterface

// File: exe_pkg.sv
package exe_pkg;

    // datapath widths
    localparam int WORD_W   = 32;
    localparam int HALF_W   = WORD_W / 2;
    localparam int SHAMT_W  = 5;
    localparam int NUM_REGS = 32;

    // byte distance to the fall-through instruction
    localparam int LINK_OFFSET = 4;

    typedef logic [WORD_W-1:0]           word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

    // raw opcode field, meaning depends on the lane-0 kind
    typedef logic [3:0] func_t;

    // unit that takes a lane-0 item
    typedef enum logic [1:0] {
        KIND_ALU,
        KIND_MUL,
        KIND_BR
    } kind_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    // same codes as the branch condition field of the uop
    typedef enum logic [3:0] {
        BR_JIRL = 4'b0011,
        BR_B    = 4'b0100,
        BR_BL   = 4'b0101,
        BR_BEQ  = 4'b0110,
        BR_BNE  = 4'b0111,
        BR_BLT  = 4'b1000,
        BR_BGE  = 4'b1001,
        BR_BLTU = 4'b1010,
        BR_BGEU = 4'b1011
    } br_op_t;

    // low word, signed high word, unsigned high word
    typedef enum logic [1:0] {
        MUL_LO,
        MUL_HI,
        MUL_HIU
    } mul_op_t;

endpackage
